// ==== include/osd_settings.svh ====
`ifndef OSD_SETTINGS_SVH
`define OSD_SETTINGS_SVH

// identity of this debug module, reported through registers 0 and 1
`define OSD_MODID 16'h0004
`define OSD_MODVERSION 16'h0001

// stall bit in the control/status register is writable
`define OSD_CAN_STALL 1

// width of the internal request/response value register
`define OSD_MAX_REG_SIZE 16

// external register map, four scratch registers then the write counter
`define OSD_EXT_SCRATCH_BASE 16'h0200
`define OSD_EXT_WRCOUNT_ADDR 16'h0204

`endif

// ==== hdl/dii_package.sv ====
package dii_package;

   // one data word of a debug packet
   typedef logic [15:0] dii_word;

   // module address on the debug interconnect
   typedef logic [9:0] dii_id;

   // flit of a debug stream, ready travels separately
   typedef struct packed {
      logic valid;
      logic last;
      dii_word data;
   } dii_flit;

endpackage

// ==== hdl/osd_flit_buffer.sv ====
module osd_flit_buffer (
   input logic clk,
   input logic rst,
   input dii_package::dii_flit in,
   output logic in_ready,
   output dii_package::dii_flit out,
   input logic out_ready
);
   import dii_package::*;

   dii_flit mem [2];

   logic wr_ptr;
   logic rd_ptr;
   logic [1:0] count;
   logic push;
   logic pop;

   // registered count, so out_ready never reaches in_ready combinationally
   assign in_ready = (count != 2'd2);
   assign push = in.valid & in_ready;
   assign pop = out.valid & out_ready;

   always_comb begin
      out = mem[rd_ptr];
      out.valid = (count != 2'd0);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, pop})
            2'b10: count <= count + 2'd1;
            2'b01: count <= count - 2'd1;
            default: count <= count; // both or neither
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in;
      end
   end

endmodule

// ==== hdl/osd_ext_regfile.sv ====
`include "osd_settings.svh"

module osd_ext_regfile (
   input logic clk,
   input logic rst,
   input logic reg_request,
   input logic reg_write,
   input dii_package::dii_word reg_addr,
   input logic [1:0] reg_size,
   input dii_package::dii_word reg_wdata,
   output logic reg_ack,
   output logic reg_err,
   output dii_package::dii_word reg_rdata
);
   import dii_package::*;

   localparam int NUM_SCRATCH = 4;

   dii_word scratch [NUM_SCRATCH];
   dii_word wr_count;

   logic take;
   logic is_scratch;
   logic is_count;
   logic access_err;
   logic [1:0] idx;

   // request still high during the ack cycle, so skip that one
   assign take = reg_request & ~reg_ack & ~reg_err;

   assign idx = reg_addr[1:0];
   assign is_scratch = (reg_addr[15:2] == 14'(`OSD_EXT_SCRATCH_BASE >> 2));
   assign is_count = (reg_addr == `OSD_EXT_WRCOUNT_ADDR);

   always_comb begin
      access_err = 1'b0;
      if (reg_size != 2'b00) begin
         access_err = 1'b1; // 16 bit only
      end
      if (!is_scratch && !is_count) begin
         access_err = 1'b1;
      end
      if (reg_write && is_count) begin
         access_err = 1'b1; // counter is read only
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_ack <= 1'b0;
         reg_err <= 1'b0;
         wr_count <= '0;
         for (int i = 0; i < NUM_SCRATCH; i++) begin
            scratch[i] <= '0;
         end
      end else begin
         reg_ack <= take & ~access_err;
         reg_err <= take & access_err;
         if (take && !access_err && reg_write) begin
            scratch[idx] <= reg_wdata;
            wr_count <= wr_count + 16'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         reg_rdata <= is_count ? wr_count : scratch[idx];
      end
   end

endmodule

// ==== hdl/osd_regaccess.sv ====
`include "osd_settings.svh"

module osd_regaccess #(
   parameter logic [15:0] MODID = `OSD_MODID,
   parameter logic [15:0] MODVERSION = `OSD_MODVERSION,
   parameter int CAN_STALL = `OSD_CAN_STALL,
   parameter int MAX_REG_SIZE = `OSD_MAX_REG_SIZE
) (
   input logic clk,
   input logic rst,
   input dii_package::dii_id id,
   input dii_package::dii_flit debug_in,
   output logic debug_in_ready,
   output dii_package::dii_flit debug_out,
   input logic debug_out_ready,
   output logic reg_request,
   output logic reg_write,
   output dii_package::dii_word reg_addr,
   output logic [1:0] reg_size,
   output dii_package::dii_word reg_wdata,
   input logic reg_ack,
   input logic reg_err,
   input dii_package::dii_word reg_rdata,
   output logic stall
);
   import dii_package::*;

   localparam logic [1:0] REQ_SIZE_16 = 2'b00;

   localparam dii_word REG_MODID = 16'h0000;
   localparam dii_word REG_VERSION = 16'h0001;
   localparam dii_word REG_CS = 16'h0003;

   localparam logic [4:0] CS_STALL = 5'h01; // command field, bits 15..11

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_START,
      ST_ADDR,
      ST_WRITE,
      ST_EXT_DATA,
      ST_EXT_REQ,
      ST_RESP_START,
      ST_RESP_SRC,
      ST_RESP_VALUE,
      ST_DROP
   } state_t;

   state_t state, nxt_state;

   logic mod_cs_stall, nxt_mod_cs_stall;

   // request fields and response data
   logic req_write, nxt_req_write;
   logic [1:0] req_size, nxt_req_size;
   dii_word req_addr, nxt_req_addr;
   logic [MAX_REG_SIZE-1:0] reqresp_value, nxt_reqresp_value;
   dii_id resp_dest, nxt_resp_dest;
   logic resp_error, nxt_resp_error;

   logic addr_is_ext;

   assign addr_is_ext = (debug_in.data[15:9] != 7'd0); // 0x200 and up
   assign stall = (CAN_STALL != 0) ? mod_cs_stall : 1'b0;

   assign reg_write = req_write;
   assign reg_addr = req_addr;
   assign reg_size = req_size;
   assign reg_wdata = reqresp_value[15:0];

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         mod_cs_stall <= 1'b1;
      end else begin
         state <= nxt_state;
         mod_cs_stall <= nxt_mod_cs_stall;
      end
   end

   always_ff @(posedge clk) begin
      req_write <= nxt_req_write;
      req_size <= nxt_req_size;
      req_addr <= nxt_req_addr;
      reqresp_value <= nxt_reqresp_value;
      resp_dest <= nxt_resp_dest;
      resp_error <= nxt_resp_error;
   end

   always_comb begin
      nxt_state = state;
      nxt_mod_cs_stall = mod_cs_stall;
      nxt_req_write = req_write;
      nxt_req_size = req_size;
      nxt_req_addr = req_addr;
      nxt_reqresp_value = reqresp_value;
      nxt_resp_dest = resp_dest;
      nxt_resp_error = resp_error;

      debug_in_ready = 1'b0;
      debug_out = '0;
      reg_request = 1'b0;

      case (state)
         ST_IDLE: begin
            debug_in_ready = 1'b1;
            // single flit packet carries no request
            if (debug_in.valid && !debug_in.last) begin
               nxt_state = ST_START;
            end
         end
         ST_START: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_req_write = debug_in.data[12];
               nxt_req_size = debug_in.data[11:10];
               nxt_resp_dest = debug_in.data[9:0];
               nxt_resp_error = 1'b0;
               if (debug_in.data[15:14] != 2'b00) begin
                  nxt_state = debug_in.last ? ST_IDLE : ST_DROP; // not ours
               end else if (debug_in.last) begin
                  nxt_state = ST_IDLE; // no address word
               end else begin
                  nxt_state = ST_ADDR;
               end
            end
         end
         ST_ADDR: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_req_addr = debug_in.data;
               if (addr_is_ext) begin
                  if (!req_write) begin
                     nxt_state = debug_in.last ? ST_EXT_REQ : ST_DROP;
                  end else if (debug_in.last) begin
                     nxt_resp_error = 1'b1; // write without data
                     nxt_state = ST_RESP_START;
                  end else begin
                     nxt_state = ST_EXT_DATA;
                  end
               end else if (req_write) begin
                  if (req_size != REQ_SIZE_16 || debug_in.data != REG_CS) begin
                     nxt_resp_error = 1'b1;
                  end
                  if (debug_in.last) begin
                     nxt_resp_error = 1'b1;
                     nxt_state = ST_RESP_START;
                  end else begin
                     nxt_state = ST_WRITE; // data word is consumed even on error
                  end
               end else begin
                  case (debug_in.data)
                     REG_MODID: nxt_reqresp_value = MAX_REG_SIZE'(MODID);
                     REG_VERSION: nxt_reqresp_value = MAX_REG_SIZE'(MODVERSION);
                     default: nxt_resp_error = 1'b1;
                  endcase
                  if (req_size != REQ_SIZE_16) begin
                     nxt_resp_error = 1'b1;
                  end
                  nxt_state = debug_in.last ? ST_RESP_START : ST_DROP;
               end
            end
         end
         ST_WRITE: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               // only the control/status register gets here without error
               if (!resp_error) begin
                  if (debug_in.data[15:11] == CS_STALL && CAN_STALL != 0) begin
                     nxt_mod_cs_stall = debug_in.data[0];
                  end else begin
                     nxt_resp_error = 1'b1;
                  end
               end
               nxt_state = debug_in.last ? ST_RESP_START : ST_DROP;
            end
         end
         ST_EXT_DATA: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_reqresp_value = MAX_REG_SIZE'(debug_in.data);
               nxt_state = debug_in.last ? ST_EXT_REQ : ST_DROP;
            end
         end
         ST_EXT_REQ: begin
            reg_request = 1'b1;
            if (reg_ack || reg_err) begin
               nxt_reqresp_value = MAX_REG_SIZE'(reg_rdata);
               nxt_resp_error = reg_err;
               nxt_state = ST_RESP_START;
            end
         end
         ST_RESP_START: begin
            debug_out.valid = 1'b1;
            debug_out.data = {6'h00, resp_dest};
            if (debug_out_ready) begin
               nxt_state = ST_RESP_SRC;
            end
         end
         ST_RESP_SRC: begin
            debug_out.valid = 1'b1;
            debug_out.last = resp_error | req_write;
            debug_out.data = {4'h0, req_write, resp_error, id};
            if (debug_out_ready) begin
               nxt_state = (resp_error || req_write) ? ST_IDLE : ST_RESP_VALUE;
            end
         end
         ST_RESP_VALUE: begin
            debug_out.valid = 1'b1;
            debug_out.last = 1'b1;
            debug_out.data = reqresp_value[15:0];
            if (debug_out_ready) begin
               nxt_state = ST_IDLE;
            end
         end
         ST_DROP: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid && debug_in.last) begin
               nxt_state = ST_IDLE;
            end
         end
         default: nxt_state = ST_IDLE;
      endcase
   end

endmodule

// ==== hdl/osd_regaccess_top.sv ====
module osd_regaccess_top (
   input logic clk,
   input logic rst,
   input dii_package::dii_id id,
   input dii_package::dii_flit debug_in,
   output logic debug_in_ready,
   output dii_package::dii_flit debug_out,
   input logic debug_out_ready,
   output logic stall
);
   import dii_package::*;

   dii_flit buf_in;
   logic buf_ready;

   // register port
   logic reg_request;
   logic reg_write;
   dii_word reg_addr;
   logic [1:0] reg_size;
   dii_word reg_wdata;
   logic reg_ack;
   logic reg_err;
   dii_word reg_rdata;

   osd_regaccess i_regaccess (
      .clk(clk),
      .rst(rst),
      .id(id),
      .debug_in(debug_in),
      .debug_in_ready(debug_in_ready),
      .debug_out(buf_in),
      .debug_out_ready(buf_ready),
      .reg_request(reg_request),
      .reg_write(reg_write),
      .reg_addr(reg_addr),
      .reg_size(reg_size),
      .reg_wdata(reg_wdata),
      .reg_ack(reg_ack),
      .reg_err(reg_err),
      .reg_rdata(reg_rdata),
      .stall(stall)
   );

   osd_ext_regfile i_regfile (
      .clk(clk),
      .rst(rst),
      .reg_request(reg_request),
      .reg_write(reg_write),
      .reg_addr(reg_addr),
      .reg_size(reg_size),
      .reg_wdata(reg_wdata),
      .reg_ack(reg_ack),
      .reg_err(reg_err),
      .reg_rdata(reg_rdata)
   );

   // response path to the debug link
   osd_flit_buffer i_buffer (
      .clk(clk),
      .rst(rst),
      .in(buf_in),
      .in_ready(buf_ready),
      .out(debug_out),
      .out_ready(debug_out_ready)
   );

endmodule

// ==== sim/osd_regaccess_sva.sv ====
module osd_regaccess_sva (
   input logic clk,
   input logic rst,
   input logic reg_request,
   input logic reg_ack,
   input logic reg_err,
   input dii_package::dii_flit debug_out,
   input logic debug_out_ready
);

   // request may only fall once the register file has answered
   property request_held;
      @(posedge clk) disable iff (rst)
         reg_request && !reg_ack && !reg_err |=> reg_request;
   endproperty

   property single_answer;
      @(posedge clk) disable iff (rst) !(reg_ack && reg_err);
   endproperty

   property out_stable;
      @(posedge clk) disable iff (rst)
         debug_out.valid && !debug_out_ready |=> $stable(debug_out);
   endproperty

   assert property (request_held) else $error("reg_request fell before ack or error");
   assert property (single_answer) else $error("reg_ack and reg_err high together");
   assert property (out_stable) else $error("response flit changed while stalled");

endmodule

// ==== sim/osd_regaccess_tb.sv ====
`include "osd_settings.svh"

module osd_regaccess_tb;
   import dii_package::*;

   localparam int DRIVE_DELAY = 2;
   localparam int WAIT_LIMIT = 200;
   localparam dii_id DUT_ID = 10'h07a;

   typedef struct {
      string name;
      logic [1:0] ptype;
      logic wr;
      logic [1:0] size;
      dii_word addr;
      dii_word data;
      logic exp_err;
      dii_word exp_val;
   } test_t;

   logic clk;
   logic rst;
   dii_id id;
   dii_flit debug_in;
   logic debug_in_ready;
   dii_flit debug_out;
   logic debug_out_ready;
   logic stall;

   test_t tests[$];
   dii_word resp[$];
   logic [31:0] rng = 32'hc1a3;
   int mismatches = 0;
   int errors = 0;
   logic exp_stall;

   osd_regaccess_top i_dut (.*);

   bind osd_regaccess osd_regaccess_sva i_sva (
      .clk(clk),
      .rst(rst),
      .reg_request(reg_request),
      .reg_ack(reg_ack),
      .reg_err(reg_err),
      .debug_out(debug_out),
      .debug_out_ready(debug_out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   always @(posedge clk) begin
      #DRIVE_DELAY;
      rng = xorshift32(rng);
      debug_out_ready = rng[3] | rng[9]; // ready about three cycles in four
   end

   task automatic compare(input string name, input logic [31:0] exp,
                          input logic [31:0] act);
      if (exp !== act) begin
         mismatches++;
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic fill_tests;
      dii_word base;
      base = `OSD_EXT_SCRATCH_BASE;
      tests.push_back('{"read modid", 2'b00, 1'b0, 2'b00, 16'h0000, 16'h0, 1'b0, `OSD_MODID});
      tests.push_back('{"read version", 2'b00, 1'b0, 2'b00, 16'h0001, 16'h0, 1'b0,
                        `OSD_MODVERSION});
      tests.push_back('{"clear stall", 2'b00, 1'b1, 2'b00, 16'h0003, 16'h0800, 1'b0, 16'h0});
      tests.push_back('{"write version", 2'b00, 1'b1, 2'b00, 16'h0001, 16'h0801, 1'b1, 16'h0});
      tests.push_back('{"cs size 32", 2'b00, 1'b1, 2'b01, 16'h0003, 16'h0801, 1'b1, 16'h0});
      for (int n = 0; n < 4; n++) begin
         tests.push_back('{$sformatf("write scratch %0d", n), 2'b00, 1'b1, 2'b00,
                           base + 16'(n), 16'ha5c3 + 16'(n) * 16'h1111, 1'b0, 16'h0});
      end
      // refused size, so the scratch value and the counter stay
      tests.push_back('{"ext size 32", 2'b00, 1'b1, 2'b01, base + 16'h1, 16'hdead, 1'b1, 16'h0});
      for (int n = 0; n < 4; n++) begin
         tests.push_back('{$sformatf("read scratch %0d", n), 2'b00, 1'b0, 2'b00,
                           base + 16'(n), 16'h0, 1'b0, 16'ha5c3 + 16'(n) * 16'h1111});
      end
      tests.push_back('{"read count", 2'b00, 1'b0, 2'b00, `OSD_EXT_WRCOUNT_ADDR, 16'h0, 1'b0,
                        16'd4});
      tests.push_back('{"read unmapped", 2'b00, 1'b0, 2'b00, 16'h0210, 16'h0, 1'b1, 16'h0});
      tests.push_back('{"write count", 2'b00, 1'b1, 2'b00, `OSD_EXT_WRCOUNT_ADDR, 16'h7, 1'b1,
                        16'h0});
      tests.push_back('{"not a reg access", 2'b01, 1'b0, 2'b00, 16'h0000, 16'h0, 1'b0, 16'h0});
      tests.push_back('{"read after drop", 2'b00, 1'b0, 2'b00, 16'h0000, 16'h0, 1'b0,
                        `OSD_MODID});
   endtask

   // called just after a rising edge, returns just after the accepting edge
   task automatic send_flit(input dii_word data, input logic last);
      int n;
      n = 0;
      debug_in = '{valid: 1'b1, last: last, data: data};
      @(negedge clk);
      while (!debug_in_ready && n < WAIT_LIMIT) begin
         n++;
         @(negedge clk);
      end
      if (!debug_in_ready) begin
         errors++;
         $display("request flit %h was not accepted within %0d cycles", data, WAIT_LIMIT);
      end
      @(posedge clk);
      #DRIVE_DELAY;
      debug_in = '0;
   endtask

   task automatic send_packet(input test_t t, input dii_id src);
      send_flit({6'h00, DUT_ID}, 1'b0);
      send_flit({t.ptype, 1'b0, t.wr, t.size, src}, 1'b0);
      send_flit(t.addr, !t.wr);
      if (t.wr) begin
         send_flit(t.data, 1'b1);
      end
   endtask

   task automatic collect_response(input string name);
      int n;
      logic done;
      resp.delete();
      done = 1'b0;
      while (!done && resp.size() < 4) begin
         n = 0;
         @(negedge clk);
         while (!(debug_out.valid && debug_out_ready) && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
         end
         if (debug_out.valid && debug_out_ready) begin
            resp.push_back(debug_out.data);
            done = debug_out.last;
         end else begin
            errors++;
            $display("%s: no response flit within %0d cycles", name, WAIT_LIMIT);
            done = 1'b1;
         end
      end
   endtask

   task automatic expect_silence(input string name);
      logic seen;
      seen = 1'b0;
      repeat (30) begin
         @(negedge clk);
         seen = seen | debug_out.valid;
      end
      if (seen) begin
         errors++;
         $display("%s: a response came for a packet that is not a register access", name);
      end
   endtask

   initial begin
      int exp_len;
      dii_id src;
      rst = 1'b1;
      id = DUT_ID;
      debug_in = '0;
      debug_out_ready = 1'b0;
      fill_tests();
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      exp_stall = (`OSD_CAN_STALL != 0);
      @(negedge clk);
      compare("stall after reset", exp_stall, stall);
      compare("input ready after reset", 1'b1, debug_in_ready);
      compare("output valid after reset", 1'b0, debug_out.valid);
      foreach (tests[i]) begin
         src = 10'h010 + 10'(i);
         @(posedge clk);
         #DRIVE_DELAY;
         send_packet(tests[i], src);
         if (tests[i].ptype != 2'b00) begin
            expect_silence(tests[i].name);
         end else begin
            collect_response(tests[i].name);
            exp_len = (tests[i].exp_err || tests[i].wr) ? 2 : 3;
            compare({tests[i].name, " length"}, exp_len, resp.size());
            if (resp.size() >= 2) begin
               compare({tests[i].name, " dest"}, {6'h00, src}, resp[0]);
               compare({tests[i].name, " source"},
                       {4'h0, tests[i].wr, tests[i].exp_err, DUT_ID}, resp[1]);
            end
            if (exp_len == 3 && resp.size() == 3) begin
               compare({tests[i].name, " value"}, tests[i].exp_val, resp[2]);
            end
            // accepted control/status write carries the new stall in bit 0
            if (tests[i].wr && tests[i].addr == 16'h0003 && !tests[i].exp_err) begin
               exp_stall = tests[i].data[0];
            end
            compare({tests[i].name, " stall"}, exp_stall, stall);
         end
      end
      $display("%0d mismatches, %0d other errors", mismatches, errors);
      if (mismatches == 0 && errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
hdl/dii_package.sv
hdl/osd_flit_buffer.sv
hdl/osd_ext_regfile.sv
hdl/osd_regaccess.sv
hdl/osd_regaccess_top.sv
sim/osd_regaccess_sva.sv
sim/osd_regaccess_tb.sv

// ==== Bender.yml ====
package:
  name: osd_regaccess

export_include_dirs:
  - include

sources:
  - hdl/dii_package.sv
  - hdl/osd_flit_buffer.sv
  - hdl/osd_ext_regfile.sv
  - hdl/osd_regaccess.sv
  - hdl/osd_regaccess_top.sv
  - target: simulation
    files:
      - sim/osd_regaccess_sva.sv
      - sim/osd_regaccess_tb.sv
